// ==== logic/bit_gearbox.sv ====
`timescale 1ns/10ps
`include "vec_decode_consts.svh"

module bit_gearbox
(
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  logic [`VEC_WORD_W-1:0]  in_data,
  input  logic                    group_pop,
  output logic                    in_ready,
  output logic                    group_avail,
  output logic [`VEC_GROUP_W-1:0] group_bits
);

  localparam int cnt_w = $clog2(`VEC_BUF_W + 1);

  logic [`VEC_BUF_W-1:0] bit_buf; // valid bits left aligned, zeros below
  logic [cnt_w-1:0]      bit_cnt;
  logic [`VEC_BUF_W-1:0] buf_popped;
  logic [cnt_w-1:0]      cnt_popped;
  logic [`VEC_BUF_W-1:0] word_aligned;
  logic                  accept;

  assign in_ready    = bit_cnt <= cnt_w'(`VEC_BUF_W - `VEC_WORD_W);
  assign group_avail = bit_cnt >= cnt_w'(`VEC_GROUP_W);
  assign group_bits  = bit_buf[`VEC_BUF_W-1 -: `VEC_GROUP_W];
  assign accept      = in_valid && in_ready;

  // pop first, then the new word lands right below what is left
  assign buf_popped   = group_pop ? (bit_buf << `VEC_GROUP_W) : bit_buf;
  assign cnt_popped   = group_pop ? (bit_cnt - cnt_w'(`VEC_GROUP_W)) : bit_cnt;
  assign word_aligned = {in_data, {(`VEC_BUF_W - `VEC_WORD_W){1'b0}}} >> cnt_popped;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bit_buf <= '0;
      bit_cnt <= '0;
    end
    else if (accept)
    begin
      bit_buf <= buf_popped | word_aligned;
      bit_cnt <= cnt_popped + cnt_w'(`VEC_WORD_W);
    end
    else
    begin
      bit_buf <= buf_popped;
      bit_cnt <= cnt_popped;
    end
  end

  a_cnt_bound: assert property (@(posedge clk) disable iff (reset)
    bit_cnt <= cnt_w'(`VEC_BUF_W));

  // ctrl must not pop a partial group
  a_pop_avail: assert property (@(posedge clk) disable iff (reset)
    group_pop |-> group_avail);

endmodule

// ==== logic/vec_decode_consts.svh ====
`ifndef VEC_DECODE_CONSTS_SVH
`define VEC_DECODE_CONSTS_SVH

// input stream word, MSB first
`define VEC_WORD_W 32

// one prefix terminator plus a rice suffix of VEC_GRK bits
`define VEC_GROUP_W 6
`define VEC_GRK 5

`define VEC_BUF_W 64 // gearbox capacity in bits

`define VEC_TAB_N 16 // entries per inverse table

`endif

// ==== logic/vec_decode_ctrl.sv ====
`timescale 1ns/10ps

module vec_decode_ctrl
(
  input  logic clk,
  input  logic reset,
  input  logic group_avail,
  input  logic out_ready,
  output logic group_pop,
  output logic out_valid
);

  vec_decode_pkg::ctrl_state_t state;
  vec_decode_pkg::ctrl_state_t state_nxt;
  logic                        slot_free;

  assign out_valid = state != vec_decode_pkg::st_empty;
  assign slot_free = !out_valid || out_ready; // held symbol leaves this edge
  assign group_pop = group_avail && slot_free;

  always_comb
  begin
    case (state)
      vec_decode_pkg::st_empty:
        state_nxt = group_avail ? vec_decode_pkg::st_full : vec_decode_pkg::st_empty;
      vec_decode_pkg::st_full,
      vec_decode_pkg::st_stall:
      begin
        if (!out_ready)
          state_nxt = vec_decode_pkg::st_stall;
        else if (group_avail)
          state_nxt = vec_decode_pkg::st_full; // back to back
        else
          state_nxt = vec_decode_pkg::st_empty;
      end
      default:
        state_nxt = vec_decode_pkg::st_empty;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      state <= vec_decode_pkg::st_empty;
    else
      state <= state_nxt;
  end

  // a presented symbol may not be withdrawn before the sink takes it
  a_valid_hold: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid);

endmodule

// ==== logic/vec_decode_pkg.sv ====
package vec_decode_pkg;

  typedef enum logic [0:0] {
    comp_luma   = 1'b0,
    comp_chroma = 1'b1
  } component_t;

  typedef enum logic [1:0] {
    st_empty = 2'd0, // nothing presented
    st_full  = 2'd1, // symbol on the output
    st_stall = 2'd2  // refused by the sink last cycle
  } ctrl_state_t;

  typedef logic [3:0] symbol_t; // sample i sits in bit 3-i

  function automatic symbol_t luma_inv(input logic [3:0] code_num);
    case (code_num)
      4'd0:    luma_inv = 4'd2;
      4'd1:    luma_inv = 4'd1;
      4'd2:    luma_inv = 4'd8;
      4'd3:    luma_inv = 4'd4;
      4'd4:    luma_inv = 4'd10;
      4'd5:    luma_inv = 4'd5;
      4'd6:    luma_inv = 4'd3;
      4'd7:    luma_inv = 4'd9;
      4'd8:    luma_inv = 4'd6;
      4'd9:    luma_inv = 4'd12;
      4'd10:   luma_inv = 4'd7;
      4'd11:   luma_inv = 4'd11;
      4'd12:   luma_inv = 4'd14;
      4'd13:   luma_inv = 4'd13;
      4'd14:   luma_inv = 4'd15;
      default: luma_inv = 4'd0;
    endcase
  endfunction

  function automatic symbol_t chroma_inv(input logic [3:0] code_num);
    case (code_num)
      4'd0:    chroma_inv = 4'd2;
      4'd1:    chroma_inv = 4'd1;
      4'd2:    chroma_inv = 4'd4;
      4'd3:    chroma_inv = 4'd8;
      4'd4:    chroma_inv = 4'd3;
      4'd5:    chroma_inv = 4'd12;
      4'd6:    chroma_inv = 4'd10;
      4'd7:    chroma_inv = 4'd5;
      4'd8:    chroma_inv = 4'd6;
      4'd9:    chroma_inv = 4'd9;
      4'd10:   chroma_inv = 4'd11;
      4'd11:   chroma_inv = 4'd7;
      4'd12:   chroma_inv = 4'd13;
      4'd13:   chroma_inv = 4'd14;
      4'd14:   chroma_inv = 4'd15;
      default: chroma_inv = 4'd0;
    endcase
  endfunction

endpackage

// ==== logic/vec_decode_top.sv ====
`timescale 1ns/10ps
`include "vec_decode_consts.svh"

module vec_decode_top
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        in_valid,
  input  logic [`VEC_WORD_W-1:0]      in_data,
  input  vec_decode_pkg::component_t  component,
  input  logic                        out_ready,
  output logic                        in_ready,
  output logic                        out_valid,
  output vec_decode_pkg::symbol_t     out_symbol,
  output logic                        out_code_err
);

  logic                    group_avail;
  logic [`VEC_GROUP_W-1:0] group_bits;
  logic                    group_pop;

  bit_gearbox bit_gearbox_i (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_data     (in_data),
    .group_pop   (group_pop),
    .in_ready    (in_ready),
    .group_avail (group_avail),
    .group_bits  (group_bits)
  );

  vec_symbol_map vec_symbol_map_i (
    .clk        (clk),
    .reset      (reset),
    .load       (group_pop), // same edge that drops the group
    .group_bits (group_bits),
    .component  (component),
    .symbol     (out_symbol),
    .code_err   (out_code_err)
  );

  vec_decode_ctrl vec_decode_ctrl_i (
    .clk         (clk),
    .reset       (reset),
    .group_avail (group_avail),
    .out_ready   (out_ready),
    .group_pop   (group_pop),
    .out_valid   (out_valid)
  );

endmodule

// ==== logic/vec_symbol_map.sv ====
`timescale 1ns/10ps
`include "vec_decode_consts.svh"

module vec_symbol_map
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        load,
  input  logic [`VEC_GROUP_W-1:0]     group_bits,
  input  vec_decode_pkg::component_t  component,
  output vec_decode_pkg::symbol_t     symbol,
  output logic                        code_err
);

  logic [`VEC_GRK-1:0]     code_num;
  logic                    code_ok;
  vec_decode_pkg::symbol_t symbol_nxt;

  // prefix length is always zero here, the top bit is just its terminator
  assign code_num = group_bits[`VEC_GRK-1:0];
  assign code_ok  = code_num < `VEC_GRK'(`VEC_TAB_N);

  always_comb
  begin
    if (!code_ok)
      symbol_nxt = '0; // outside the table
    else if (component == vec_decode_pkg::comp_luma)
      symbol_nxt = vec_decode_pkg::luma_inv(code_num[3:0]);
    else
      symbol_nxt = vec_decode_pkg::chroma_inv(code_num[3:0]);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      symbol   <= '0;
      code_err <= 1'b0;
    end
    else if (load)
    begin
      symbol   <= symbol_nxt;
      code_err <= !code_ok;
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the vec_decode testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

rm -rf "$build_dir"

verilator --binary --timing --assert \
  -f vec_decode_top.f \
  --top-module vec_decode_tb \
  --Mdir "$build_dir" \
  -o vec_decode_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/vec_decode_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "STATUS: FAIL" "$log_file"; then
  exit 1
fi
exit 0

// ==== sim/vec_decode_tb.sv ====
`timescale 1ns/10ps
`include "vec_decode_consts.svh"

module vec_decode_tb;

  localparam int total_words = 45; // 3 + 6 + 3 + 3 + 30 over all tests
  localparam int wd_cycles   = total_words * 40 + 200;

  logic                       clk;
  logic                       reset;
  logic                       in_valid;
  logic [`VEC_WORD_W-1:0]     in_data;
  vec_decode_pkg::component_t component;
  logic                       out_ready;
  logic                       in_ready;
  logic                       out_valid;
  vec_decode_pkg::symbol_t    out_symbol;
  logic                       out_code_err;

  logic [31:0]                lfsr;
  vec_decode_pkg::component_t cur_comp; // component the model decodes with
  logic                       rand_valid;
  logic                       rand_ready;
  logic                       bit_q[$];
  vec_decode_pkg::symbol_t    exp_sym_q[$];
  logic                       exp_err_q[$];
  int                         got_cnt;
  int                         value_errs;
  int                         proto_errs;
  logic                       held; // symbol refused at the last sample
  vec_decode_pkg::symbol_t    held_sym;
  logic                       held_err;

  vec_decode_top vec_decode_top_i (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_data      (in_data),
    .component    (component),
    .out_ready    (out_ready),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .out_symbol   (out_symbol),
    .out_code_err (out_code_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // taps 32 22 2 1
  function automatic logic rand_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], rand_bit()};
    return v;
  endfunction

  task automatic check_symbol(input string name, input vec_decode_pkg::symbol_t exp_v,
                              input vec_decode_pkg::symbol_t act_v);
    if (act_v !== exp_v)
    begin
      value_errs++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
    end
  endtask

  task automatic check_bit(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v)
    begin
      value_errs++;
      $display("ERR %0t %s expected %b actual %b", $time, name, exp_v, act_v);
    end
  endtask

  task automatic expect_group(input logic [`VEC_GROUP_W-1:0] grp);
    logic [`VEC_GRK-1:0] code;
    code = grp[`VEC_GRK-1:0]; // top bit only ends the empty prefix
    if (code >= 5'd16)
    begin
      exp_sym_q.push_back(4'd0);
      exp_err_q.push_back(1'b1);
    end
    else if (cur_comp == vec_decode_pkg::comp_luma)
    begin
      exp_sym_q.push_back(vec_decode_pkg::luma_inv(code[3:0]));
      exp_err_q.push_back(1'b0);
    end
    else
    begin
      exp_sym_q.push_back(vec_decode_pkg::chroma_inv(code[3:0]));
      exp_err_q.push_back(1'b0);
    end
  endtask

  task automatic model_push(input logic [`VEC_WORD_W-1:0] w);
    logic [`VEC_GROUP_W-1:0] grp;
    grp = '0;
    for (int b = `VEC_WORD_W - 1; b >= 0; b--)
    begin
      bit_q.push_back(w[b]);
      if (bit_q.size() == `VEC_GROUP_W)
      begin
        for (int k = 0; k < `VEC_GROUP_W; k++)
          grp = {grp[`VEC_GROUP_W-2:0], bit_q.pop_front()};
        expect_group(grp);
      end
    end
  endtask

  task automatic watch_output;
    vec_decode_pkg::symbol_t exp_sym;
    logic                    exp_err;
    if (held)
    begin
      if (!out_valid)
      begin
        proto_errs++;
        $display("%0t: out_valid dropped before the stalled symbol was taken", $time);
      end
      check_symbol("out_symbol", held_sym, out_symbol);
      check_bit("out_code_err", held_err, out_code_err);
    end
    held     = out_valid && !out_ready;
    held_sym = out_symbol;
    held_err = out_code_err;
    if (out_valid && out_ready)
    begin
      got_cnt++;
      if (exp_sym_q.size() == 0)
      begin
        proto_errs++;
        $display("%0t: a symbol came out while none was expected", $time);
      end
      else
      begin
        exp_sym = exp_sym_q.pop_front();
        exp_err = exp_err_q.pop_front();
        check_symbol("out_symbol", exp_sym, out_symbol);
        check_bit("out_code_err", exp_err, out_code_err);
      end
    end
  endtask

  // outputs sampled at the falling edge, the transfer lands on the next rising one
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (!reset)
        watch_output();
    end
  end

  initial
  begin
    forever
    begin
      @(posedge clk);
      if (rand_ready)
        out_ready <= rand_bit();
      else
        out_ready <= 1'b1;
    end
  end

  task automatic send_word(input logic [`VEC_WORD_W-1:0] w);
    model_push(w);
    @(posedge clk);
    while (rand_valid && !rand_bit())
      @(posedge clk); // idle gap
    in_valid <= 1'b1;
    in_data  <= w;
    @(negedge clk);
    while (!in_ready)
      @(negedge clk);
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  // three words, sixteen groups
  function automatic logic [95:0] pack_block(input logic prefix, input logic [4:0] base);
    logic [95:0] blk;
    logic [4:0]  code;
    blk = '0;
    for (int i = 0; i < 16; i++)
    begin
      code = base + 5'(i);
      blk[95 - 6*i -: 6] = {prefix, code};
    end
    return blk;
  endfunction

  task automatic send_block(input logic [95:0] blk);
    send_word(blk[95:64]);
    send_word(blk[63:32]);
    send_word(blk[31:0]);
  endtask

  task automatic drain;
    while (exp_sym_q.size() != 0)
      @(negedge clk);
    repeat (8) @(negedge clk); // anything extra shows up here
    check_bit("out_valid", 1'b0, out_valid);
  endtask

  task automatic set_comp(input vec_decode_pkg::component_t c);
    cur_comp = c;
    @(posedge clk);
    component <= c;
  endtask

  task automatic test_reset_state;
    @(negedge clk);
    check_bit("in_ready", 1'b1, in_ready);
    check_bit("out_valid", 1'b0, out_valid);
  endtask

  task automatic test_luma_table;
    set_comp(vec_decode_pkg::comp_luma);
    send_block(pack_block(1'b0, 5'd0));
    drain();
  endtask

  task automatic test_chroma_table;
    set_comp(vec_decode_pkg::comp_chroma);
    send_block(pack_block(1'b0, 5'd0));
    send_block(pack_block(1'b1, 5'd0)); // same codes, other prefix bit
    drain();
  endtask

  task automatic test_code_errors;
    set_comp(vec_decode_pkg::comp_luma);
    send_block(pack_block(1'b1, 5'd16));
    drain();
  endtask

  task automatic test_word_straddle;
    int start_cnt;
    start_cnt = got_cnt;
    for (int i = 0; i < 3; i++)
      send_word(rand_bits(32));
    drain();
    if (got_cnt - start_cnt != 16)
    begin
      proto_errs++;
      $display("%0t: three words gave %0d symbols instead of 16", $time, got_cnt - start_cnt);
    end
  endtask

  task automatic test_random_flow;
    rand_valid = 1'b1;
    rand_ready = 1'b1;
    for (int i = 0; i < 30; i++)
      send_word(rand_bits(32));
    rand_valid = 1'b0;
    rand_ready = 1'b0;
    drain();
  endtask

  initial
  begin
    reset      = 1'b1;
    in_valid   = 1'b0;
    in_data    = '0;
    component  = vec_decode_pkg::comp_luma;
    out_ready  = 1'b1;
    cur_comp   = vec_decode_pkg::comp_luma;
    lfsr       = 32'h2aae6241;
    rand_valid = 1'b0;
    rand_ready = 1'b0;
    got_cnt    = 0;
    value_errs = 0;
    proto_errs = 0;
    held       = 1'b0;
    held_sym   = '0;
    held_err   = 1'b0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_luma_table();
    test_chroma_table();
    test_code_errors();
    test_word_straddle();
    test_random_flow();
    $display("errors: %0d value mismatches, %0d protocol failures", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    repeat (wd_cycles) @(posedge clk);
    $display("%0t: timeout, the DUT stopped moving data within %0d cycles", $time, wd_cycles);
    $display("errors: %0d value mismatches, %0d protocol failures", value_errs, proto_errs);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== vec_decode_top.f ====
+incdir+logic
logic/vec_decode_pkg.sv
logic/bit_gearbox.sv
logic/vec_symbol_map.sv
logic/vec_decode_ctrl.sv
logic/vec_decode_top.sv
sim/vec_decode_tb.sv
